//--- logic/dadda_consts.svh
`ifndef DADDA_CONSTS_SVH
`define DADDA_CONSTS_SVH

// multiplier operand width
`define DADDA_OP_W 16

// full product, twice the operand width
`define DADDA_PROD_W (2 * `DADDA_OP_W)

// one partial-product row per multiplier bit
`define DADDA_ROWS `DADDA_OP_W

// rows consumed by one 4:2 compressor row
`define DADDA_COMP_RATIO 4

`endif

//--- logic/dadda_pkg.sv
`default_nettype none

package dadda_pkg;

  `include "dadda_consts.svh"

  // single multiplicand or multiplier
  typedef logic [`DADDA_OP_W-1:0] operand_t;

  // one partial-product row, also the final result
  typedef logic [`DADDA_PROD_W-1:0] product_t;

  // operand pair on the input channel
  typedef struct packed {
    operand_t a;
    operand_t b;
  } operands_t;

  // row banks between the reduction levels
  typedef product_t [`DADDA_ROWS-1:0]   rows16_t;
  typedef product_t [`DADDA_ROWS/2-1:0] rows8_t;
  typedef product_t [`DADDA_ROWS/4-1:0] rows4_t;
  typedef product_t [`DADDA_ROWS/8-1:0] rows2_t;

endpackage

`default_nettype wire

//--- logic/partial_product_gen.sv
`default_nettype none

`include "dadda_consts.svh"

module partial_product_gen (
  input  dadda_pkg::operands_t operands,
  output dadda_pkg::rows16_t   rows
);

  import dadda_pkg::*;

  // one AND-array row per bit of b
  for (genvar i = 0; i < `DADDA_ROWS; i++) begin : g_row
    operand_t a_masked;
    product_t a_wide;

    // a gated by multiplier bit i
    assign a_masked = operands.a & {`DADDA_OP_W{operands.b[i]}};

    // zero extend before the shift so no bits fall off
    assign a_wide = product_t'(a_masked);

    assign rows[i] = a_wide << i;
  end

endmodule

`default_nettype wire

//--- logic/compress_row_4_2.sv
`default_nettype none

`include "dadda_consts.svh"

module compress_row_4_2 (
  input  dadda_pkg::rows4_t   row_in,
  output dadda_pkg::product_t sum,
  output dadda_pkg::product_t carry
);

  import dadda_pkg::*;

  product_t carry_unshifted;

  // returns {carry, sum}
  function automatic logic [1:0] full_add(input logic x, input logic y, input logic z);
    logic s;
    logic c;
    s = x ^ y ^ z;
    c = (x & y) | (x & z) | (y & z);
    return {c, s};
  endfunction

  // one 4:2 cell per bit, two chained full adders each
  always_comb begin
    logic [1:0] fa_hi;
    logic [1:0] fa_lo;
    logic       chain;

    // no carry into bit 0
    chain = 1'b0;
    for (int i = 0; i < `DADDA_PROD_W; i++) begin
      fa_hi = full_add(row_in[0][i], row_in[1][i], row_in[2][i]);
      fa_lo = full_add(fa_hi[0], row_in[3][i], chain);
      sum[i]             = fa_lo[0];
      carry_unshifted[i] = fa_lo[1];
      // lateral carry goes into the next cell
      chain = fa_hi[1];
    end
  end

  // carry row weighs one bit more, top carry is beyond the product
  assign carry = carry_unshifted << 1;

endmodule

`default_nettype wire

//--- logic/reduction_level.sv
`default_nettype none

`include "dadda_consts.svh"

module reduction_level #(
  parameter int ROWS_IN = `DADDA_ROWS
) (
  input  dadda_pkg::product_t [ROWS_IN-1:0]   rows_in,
  output dadda_pkg::product_t [ROWS_IN/2-1:0] rows_out
);

  import dadda_pkg::*;

  localparam int GROUPS = ROWS_IN / `DADDA_COMP_RATIO;

  // each group of four rows becomes a sum and a carry row
  for (genvar g = 0; g < GROUPS; g++) begin : g_group
    rows4_t   group_rows;
    product_t group_sum;
    product_t group_carry;

    assign group_rows = rows_in[`DADDA_COMP_RATIO*g +: `DADDA_COMP_RATIO];

    compress_row_4_2 compress_row_4_2_inst (
      .row_in (group_rows),
      .sum    (group_sum),
      .carry  (group_carry)
    );

    // sum in the even slot, carry in the odd one
    assign rows_out[2*g]   = group_sum;
    assign rows_out[2*g+1] = group_carry;
  end

endmodule

`default_nettype wire

//--- logic/pipe_stage.sv
`default_nettype none

module pipe_stage #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     up_valid,
  output logic     up_ready,
  input  payload_t up_data,
  output logic     dn_valid,
  input  logic     dn_ready,
  output payload_t dn_data
);

  logic load;

  // free slot, or the current entry leaves this cycle
  assign up_ready = !dn_valid || dn_ready;
  assign load     = up_ready && up_valid;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      dn_valid <= 1'b0;
    end else if (up_ready) begin
      dn_valid <= up_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      dn_data <= up_data;
    end
  end

endmodule

`default_nettype wire

//--- logic/carry_propagate_adder.sv
`default_nettype none

`include "dadda_consts.svh"

module carry_propagate_adder (
  input  dadda_pkg::rows2_t   rows,
  output dadda_pkg::product_t sum
);

  import dadda_pkg::*;

  product_t a_row;
  product_t b_row;

  assign a_row = rows[0];
  assign b_row = rows[1];

  // plain ripple chain, carry in is zero
  always_comb begin
    logic c;

    c = 1'b0;
    for (int i = 0; i < `DADDA_PROD_W; i++) begin
      sum[i] = a_row[i] ^ b_row[i] ^ c;
      c      = (a_row[i] & b_row[i]) | (a_row[i] & c) | (b_row[i] & c);
    end
    // final carry out is beyond 32 bits
  end

endmodule

`default_nettype wire

//--- logic/dadda_mult.sv
`default_nettype none

`include "dadda_consts.svh"

module dadda_mult (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 in_valid,
  output logic                 in_ready,
  input  dadda_pkg::operands_t in_operands,
  output logic                 out_valid,
  input  logic                 out_ready,
  output dadda_pkg::product_t  out_product
);

  import dadda_pkg::*;

  rows16_t  pp_rows;
  rows8_t   lvl1_rows;
  rows8_t   s1_rows;
  rows4_t   lvl2_rows;
  rows4_t   s2_rows;
  rows2_t   lvl3_rows;
  rows2_t   s3_rows;
  product_t cpa_sum;

  logic s1_valid;
  logic s1_ready;
  logic s2_valid;
  logic s2_ready;
  logic s3_valid;
  logic s3_ready;

  // 16 rows from the AND array
  partial_product_gen partial_product_gen_inst (
    .operands (in_operands),
    .rows     (pp_rows)
  );

  // 16 to 8, ahead of the first register
  reduction_level #(.ROWS_IN(`DADDA_ROWS)) reduction_level_1_inst (
    .rows_in  (pp_rows),
    .rows_out (lvl1_rows)
  );

  pipe_stage #(.payload_t(rows8_t)) pipe_stage_1_inst (
    .clk      (clk),
    .arst_n   (arst_n),
    .up_valid (in_valid),
    .up_ready (in_ready),
    .up_data  (lvl1_rows),
    .dn_valid (s1_valid),
    .dn_ready (s1_ready),
    .dn_data  (s1_rows)
  );

  // 8 to 4
  reduction_level #(.ROWS_IN(`DADDA_ROWS/2)) reduction_level_2_inst (
    .rows_in  (s1_rows),
    .rows_out (lvl2_rows)
  );

  pipe_stage #(.payload_t(rows4_t)) pipe_stage_2_inst (
    .clk      (clk),
    .arst_n   (arst_n),
    .up_valid (s1_valid),
    .up_ready (s1_ready),
    .up_data  (lvl2_rows),
    .dn_valid (s2_valid),
    .dn_ready (s2_ready),
    .dn_data  (s2_rows)
  );

  // 4 to 2
  reduction_level #(.ROWS_IN(`DADDA_ROWS/4)) reduction_level_3_inst (
    .rows_in  (s2_rows),
    .rows_out (lvl3_rows)
  );

  pipe_stage #(.payload_t(rows2_t)) pipe_stage_3_inst (
    .clk      (clk),
    .arst_n   (arst_n),
    .up_valid (s2_valid),
    .up_ready (s2_ready),
    .up_data  (lvl3_rows),
    .dn_valid (s3_valid),
    .dn_ready (s3_ready),
    .dn_data  (s3_rows)
  );

  // last two rows merged into the product
  carry_propagate_adder carry_propagate_adder_inst (
    .rows (s3_rows),
    .sum  (cpa_sum)
  );

  // output register holds the product under back-pressure
  pipe_stage #(.payload_t(product_t)) pipe_stage_4_inst (
    .clk      (clk),
    .arst_n   (arst_n),
    .up_valid (s3_valid),
    .up_ready (s3_ready),
    .up_data  (cpa_sum),
    .dn_valid (out_valid),
    .dn_ready (out_ready),
    .dn_data  (out_product)
  );

endmodule

`default_nettype wire

//--- test/dadda_mult_tb.sv
`default_nettype none

module dadda_mult_tb;

  import dadda_pkg::*;

  localparam int HALF_PERIOD  = 20;
  localparam int DRIVE_DELAY  = 2;
  localparam int RESET_CYCLES = 16;
  // edges from the accepting edge until out_valid shows
  localparam int LATENCY      = 3;
  localparam int STREAM_OPS   = 200;
  localparam int STALL_OPS    = 100;
  // tests need roughly 600 cycles
  localparam int MAX_CYCLES   = 2000;

  logic      clk;
  logic      arst_n;
  logic      in_valid;
  logic      in_ready;
  operands_t in_operands;
  logic      out_valid;
  logic      out_ready;
  product_t  out_product;

  product_t    expected_q[$];
  product_t    expected_product;
  product_t    held_product;
  logic        held_valid;
  logic [31:0] rng_state;
  int          cycle_count;
  int          error_count;
  int          tests_passed;
  int          tests_failed;

  dadda_mult dadda_mult_inst (
    .clk         (clk),
    .arst_n      (arst_n),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .in_operands (in_operands),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_product (out_product)
  );

  always #HALF_PERIOD clk = ~clk;

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > MAX_CYCLES) begin
      $display("timeout, the run went past %0d cycles", MAX_CYCLES);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // scoreboard on both channels plus hold check while stalled
  always @(posedge clk) begin
    if (arst_n && held_valid && out_product !== held_product) begin
      $display("** Error: out_product changed while stalled, held %h now %h",
               held_product, out_product);
      error_count++;
    end
    if (arst_n && in_valid && in_ready) begin
      expected_q.push_back(product_t'(in_operands.a) * product_t'(in_operands.b));
    end
    if (arst_n && out_valid && out_ready) begin
      if (expected_q.size() == 0) begin
        $display("product %h came out with no operation outstanding", out_product);
        error_count++;
      end else begin
        expected_product = expected_q.pop_front();
        if (out_product !== expected_product) begin
          $display("** Error: out_product expected %h, got %h", expected_product, out_product);
          error_count++;
        end
      end
    end
    held_valid   = arst_n && out_valid && !out_ready;
    held_product = out_product;
  end

  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic report_test(input string name, input int errors_before);
    if (error_count == errors_before) begin
      tests_passed++;
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: %0d errors", name, error_count - errors_before);
    end
  endtask

  // holds in_valid high until the DUT takes the operands
  task automatic send_op(input operands_t ops);
    in_valid    = 1'b1;
    in_operands = ops;
    @(posedge clk);
    while (!in_ready) begin
      @(posedge clk);
    end
    #DRIVE_DELAY;
  endtask

  task automatic drain();
    while (expected_q.size() != 0) begin
      @(posedge clk);
      #DRIVE_DELAY;
    end
  endtask

  task automatic check_idle();
    if (out_valid !== 1'b0) begin
      $display("** Error: out_valid expected 0, got %h", out_valid);
      error_count++;
    end
    if (in_ready !== 1'b1) begin
      $display("** Error: in_ready expected 1, got %h", in_ready);
      error_count++;
    end
  endtask

  task automatic reset_sequence();
    int errors_before;
    errors_before = error_count;
    arst_n = 1'b0;
    repeat (RESET_CYCLES) begin
      @(posedge clk);
      #DRIVE_DELAY;
      check_idle();
    end
    arst_n = 1'b1;
    @(posedge clk);
    #DRIVE_DELAY;
    check_idle();
    report_test("reset", errors_before);
  endtask

  task automatic corner_products();
    int        errors_before;
    operands_t corners [6];
    errors_before = error_count;
    corners = '{{16'h0000, 16'h1234}, {16'habcd, 16'h0000}, {16'h0001, 16'hbeef},
                {16'hffff, 16'hffff}, {16'h8000, 16'h8000}, {16'hffff, 16'h0001}};
    out_ready = 1'b1;
    foreach (corners[i]) begin
      send_op(corners[i]);
      in_valid = 1'b0;
      drain();
    end
    report_test("corner operands", errors_before);
  endtask

  task automatic single_op_latency();
    int        errors_before;
    int        cycles;
    operands_t ops;
    errors_before = error_count;
    out_ready = 1'b1;
    ops = next_random();
    send_op(ops);
    in_valid = 1'b0;
    cycles = 0;
    while (!out_valid && cycles < 2 * LATENCY) begin
      @(posedge clk);
      #DRIVE_DELAY;
      cycles++;
    end
    if (cycles != LATENCY) begin
      $display("out_valid came %0d cycles after acceptance instead of %0d", cycles, LATENCY);
      error_count++;
    end else if (out_product !== product_t'(ops.a) * product_t'(ops.b)) begin
      $display("** Error: out_product expected %h, got %h",
               product_t'(ops.a) * product_t'(ops.b), out_product);
      error_count++;
    end
    drain();
    report_test("latency", errors_before);
  endtask

  task automatic stream_back_to_back();
    int errors_before;
    int start_cycle;
    errors_before = error_count;
    out_ready   = 1'b1;
    start_cycle = cycle_count;
    for (int i = 0; i < STREAM_OPS; i++) begin
      send_op(next_random());
    end
    in_valid = 1'b0;
    drain();
    // one per cycle until the pipeline empties
    if (cycle_count - start_cycle != STREAM_OPS + LATENCY + 1) begin
      $display("streaming took %0d cycles instead of %0d",
               cycle_count - start_cycle, STREAM_OPS + LATENCY + 1);
      error_count++;
    end
    report_test("streaming", errors_before);
  endtask

  task automatic output_backpressure();
    int          errors_before;
    int          accepted;
    int          remaining;
    logic        took;
    logic [31:0] rnd;
    errors_before = error_count;
    out_ready   = 1'b0;
    in_valid    = 1'b1;
    in_operands = next_random();
    accepted    = 0;
    repeat (8) begin
      @(posedge clk);
      took = in_ready;
      #DRIVE_DELAY;
      if (took) begin
        accepted++;
        in_operands = next_random();
      end
    end
    if (accepted != 4) begin
      $display("in_ready fell after %0d accepted operations instead of 4", accepted);
      error_count++;
    end
    if (in_ready !== 1'b0) begin
      $display("** Error: in_ready expected 0, got %h", in_ready);
      error_count++;
    end
    // the pending operand is the first of the random batch
    remaining = STALL_OPS;
    while (remaining > 0 || expected_q.size() != 0) begin
      @(posedge clk);
      took = in_valid && in_ready;
      #DRIVE_DELAY;
      if (took) begin
        remaining--;
        in_operands = next_random();
        in_valid    = (remaining > 0);
      end
      rnd       = next_random();
      out_ready = rnd[7];
    end
    out_ready = 1'b1;
    report_test("back-pressure", errors_before);
  endtask

  initial begin
    clk          = 1'b0;
    arst_n       = 1'b0;
    in_valid     = 1'b0;
    in_operands  = '0;
    out_ready    = 1'b1;
    rng_state    = 32'h2a7;
    held_valid   = 1'b0;
    held_product = '0;
    cycle_count  = 0;
    error_count  = 0;
    tests_passed = 0;
    tests_failed = 0;
    reset_sequence();
    corner_products();
    single_op_latency();
    stream_back_to_back();
    output_backpressure();
    $display("summary: %0d ok, %0d with errors, %0d errors in all", tests_passed,
             tests_failed, error_count);
    if (tests_failed == 0 && error_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- dadda_mult.f
+incdir+logic
logic/dadda_pkg.sv
logic/partial_product_gen.sv
logic/compress_row_4_2.sv
logic/reduction_level.sv
logic/pipe_stage.sv
logic/carry_propagate_adder.sv
logic/dadda_mult.sv
test/dadda_mult_tb.sv

//--- Bender.yml
package:
  name: dadda_mult

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/dadda_pkg.sv
      - logic/partial_product_gen.sv
      - logic/compress_row_4_2.sv
      - logic/reduction_level.sv
      - logic/pipe_stage.sv
      - logic/carry_propagate_adder.sv
      - logic/dadda_mult.sv
  - target: test
    files:
      - test/dadda_mult_tb.sv
